// File: flash_emu_stim.txt
# mask addr0 addr1 expected0 expected1, all hex
# mask bit 0 selects port 0, bit 1 port 1, bit 2 holds oe_n high until ready
1 00000 00000 2425 0000
2 00000 00000 0000 4A4B
3 01234 1ABCD 6869 8485
3 00155 00155 8C8D E2E3
5 1FFFF 00000 DADB 0000
1 00800 00000 3435 0000
6 00000 0C000 0000 CBCA
7 00003 00003 2223 4C4D
3 12345 00001 1617 4849
2 00000 1FFFF 0000 4849
1 0FF00 00000 DBDA 0000
3 00040 00040 A4A5 CACB

// File: sim.f
flash_emu_pkg.sv
rom_port.sv
flash_arbiter.sv
spi_flash_reader.sv
flash_emu_top.sv
spi_flash_model.sv
flash_emu_chk.sv
flash_emu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := flash_emu_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flash_emu_tb.sv
`timescale 1ns/1ps

module flash_emu_tb import flash_emu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic        SIM_CLK;
    logic        reset;
    logic        ce0_n;
    logic        oe0_n;
    word_addr_t  addr0;
    flash_word_t dq0;
    logic        dq0_oe;
    logic        ready0;
    logic        ce1_n;
    logic        oe1_n;
    word_addr_t  addr1;
    flash_word_t dq1;
    logic        dq1_oe;
    logic        ready1;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic [31:0] rng_state;

    flash_emu_top flash_emu_top_i (
        .SIM_CLK  (SIM_CLK),
        .reset    (reset),
        .ce0_n    (ce0_n),
        .oe0_n    (oe0_n),
        .addr0    (addr0),
        .dq0      (dq0),
        .dq0_oe   (dq0_oe),
        .ready0   (ready0),
        .ce1_n    (ce1_n),
        .oe1_n    (oe1_n),
        .addr1    (addr1),
        .dq1      (dq1),
        .dq1_oe   (dq1_oe),
        .ready1   (ready1),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    spi_flash_model flash_model_i (
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    initial begin
        SIM_CLK = 1'b0;
    end

    always #5 SIM_CLK = ~SIM_CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic wait_for_ready(input logic use0, input logic use1);
        int cycles;
        cycles = 0;
        while (!((ready0 || !use0) && (ready1 || !use1))) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for ready on port0 %0b port1 %0b",
                         TIMEOUT_CYCLES, use0, use1);
                stop_with_failure();
            end
            @(negedge SIM_CLK);
            cycles++;
        end
    endtask

    task automatic check_port(input logic selected, input logic rdy, input logic oe_flag,
                              input flash_word_t data, input flash_word_t expected,
                              input string name);
        if (selected) begin
            check_value(32'(rdy), 32'd1, {name, " ready"});
            check_value(32'(oe_flag), 32'd1, {name, " dq_oe"});
            check_value(32'(data), 32'(expected), {name, " dq"});
        end else begin
            check_value(32'(rdy), 32'd0, {name, " ready while unselected"});
            check_value(32'(oe_flag), 32'd0, {name, " dq_oe while unselected"});
        end
    endtask

    // Mask bit 0 selects port 0, bit 1 port 1, bit 2 keeps oe_n high until ready.
    task automatic run_line(input logic [3:0] mask, input word_addr_t a0, input word_addr_t a1,
                            input flash_word_t e0, input flash_word_t e1);
        int hold;
        addr0 = a0;
        addr1 = a1;
        oe0_n = mask[2] | !mask[0];
        oe1_n = mask[2] | !mask[1];
        ce0_n = !mask[0];
        ce1_n = !mask[1];
        wait_for_ready(mask[0], mask[1]);
        if (mask[2]) begin
            repeat (2) begin
                check_value(32'(dq0_oe), 32'd0, "port0 dq_oe with oe_n high");
                check_value(32'(dq1_oe), 32'd0, "port1 dq_oe with oe_n high");
                @(negedge SIM_CLK);
            end
            oe0_n = !mask[0];
            oe1_n = !mask[1];
            @(negedge SIM_CLK);
        end
        // The word must stay put for as long as chip-enable is held.
        rng_state = xorshift32(rng_state);
        hold = 1 + int'(rng_state[1:0]);
        repeat (hold) begin
            check_port(mask[0], ready0, dq0_oe, dq0, e0, "port0");
            check_port(mask[1], ready1, dq1_oe, dq1, e1, "port1");
            @(negedge SIM_CLK);
        end
        ce0_n = 1'b1;
        ce1_n = 1'b1;
        oe0_n = 1'b1;
        oe1_n = 1'b1;
        @(negedge SIM_CLK);
        check_value(32'(ready0), 32'd0, "ready0 after ce0_n release");
        check_value(32'(ready1), 32'd0, "ready1 after ce1_n release");
        check_value(32'(dq0_oe), 32'd0, "dq0_oe after ce0_n release");
        check_value(32'(dq1_oe), 32'd0, "dq1_oe after ce1_n release");
    endtask

    initial begin
        int          fd;
        int          n_read;
        int          n_fields;
        int          lines_run;
        int          gap;
        int          assert_errors;
        string       line;
        logic [31:0] f_mask;
        logic [31:0] f_a0;
        logic [31:0] f_a1;
        logic [31:0] f_e0;
        logic [31:0] f_e1;

        reset = 1'b1;
        ce0_n = 1'b1;
        oe0_n = 1'b1;
        addr0 = '0;
        ce1_n = 1'b1;
        oe1_n = 1'b1;
        addr1 = '0;
        rng_state = 32'h5989_0310;
        lines_run = 0;

        repeat (8) @(negedge SIM_CLK);
        reset = 1'b0;
        @(negedge SIM_CLK);
        check_value(32'(ready0), 32'd0, "ready0 after reset");
        check_value(32'(ready1), 32'd0, "ready1 after reset");
        check_value(32'(dq0_oe), 32'd0, "dq0_oe after reset");
        check_value(32'(dq1_oe), 32'd0, "dq1_oe after reset");
        check_value(32'(spi_cs_n), 32'd1, "spi_cs_n after reset");

        fd = $fopen("flash_emu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file flash_emu_stim.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            n_read = $fgets(line, fd);
            if (n_read > 0 && line.getc(0) != "#") begin
                n_fields = $sscanf(line, "%h %h %h %h %h", f_mask, f_a0, f_a1, f_e0, f_e1);
                if (n_fields == 5) begin
                    run_line(f_mask[3:0], f_a0[16:0], f_a1[16:0], f_e0[15:0], f_e1[15:0]);
                    lines_run++;
                    rng_state = xorshift32(rng_state);
                    gap = 1 + int'(rng_state[2:0]);
                    repeat (gap) @(negedge SIM_CLK);
                end else if (n_fields > 0) begin
                    $display("Malformed line in the stimulus file: %s", line);
                    stop_with_failure();
                end
            end
        end
        $fclose(fd);

        if (lines_run == 0) begin
            $display("No stimulus lines were read from flash_emu_stim.txt");
            stop_with_failure();
        end

        assert_errors = flash_emu_top_i.flash_emu_chk_i.sck_errors
                      + flash_emu_top_i.flash_emu_chk_i.oe0_errors
                      + flash_emu_top_i.flash_emu_chk_i.oe1_errors
                      + flash_emu_top_i.flash_emu_chk_i.reset_errors;
        if (assert_errors != 0) begin
            $display("The bound checker reported %0d assertion failures", assert_errors);
            stop_with_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: flash_emu_chk.sv
`timescale 1ns/1ps

module flash_emu_chk (
    input logic SIM_CLK,
    input logic reset,
    input logic spi_cs_n,
    input logic spi_sck,
    input logic oe0_n,
    input logic ready0,
    input logic dq0_oe,
    input logic oe1_n,
    input logic ready1,
    input logic dq1_oe
);

    // Failure count of each property.
    int sck_errors = 0;
    int oe0_errors = 0;
    int oe1_errors = 0;
    int reset_errors = 0;

    // The SPI clock idles low whenever the flash is deselected.
    sck_idle_low: assert property (@(posedge SIM_CLK) disable iff (reset) spi_cs_n |-> !spi_sck)
    else begin
        $error("spi_sck is high while spi_cs_n is high");
        sck_errors++;
    end

    // The output enable is ready gated by oe_n as taken on the previous edge.
    port0_oe_follows_ready: assert property (@(posedge SIM_CLK) disable iff (reset)
        dq0_oe == (ready0 && !$past(oe0_n)))
    else begin
        $error("dq0_oe does not follow ready0 and oe0_n");
        oe0_errors++;
    end

    port1_oe_follows_ready: assert property (@(posedge SIM_CLK) disable iff (reset)
        dq1_oe == (ready1 && !$past(oe1_n)))
    else begin
        $error("dq1_oe does not follow ready1 and oe1_n");
        oe1_errors++;
    end

    cs_high_after_reset: assert property (@(posedge SIM_CLK) reset |=> spi_cs_n)
    else begin
        $error("spi_cs_n is not high in the cycle after reset");
        reset_errors++;
    end

endmodule

bind flash_emu_top flash_emu_chk flash_emu_chk_i (
    .SIM_CLK  (SIM_CLK),
    .reset    (reset),
    .spi_cs_n (spi_cs_n),
    .spi_sck  (spi_sck),
    .oe0_n    (oe0_n),
    .ready0   (ready0),
    .dq0_oe   (dq0_oe),
    .oe1_n    (oe1_n),
    .ready1   (ready1),
    .dq1_oe   (dq1_oe)
);

// File: spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model import flash_emu_pkg::*; (
    input  logic spi_cs_n,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic [5:0]  in_cnt;
    logic [31:0] frame;
    logic [4:0]  out_cnt;
    flash_addr_t out_addr;
    logic [7:0]  out_byte;

    // Every byte is the XOR of its three address bytes and 5Ah.
    function automatic logic [7:0] byte_at(input flash_addr_t b);
        return b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'h5A;
    endfunction

    // Data bytes come from rising addresses after the one in the frame.
    assign out_addr = frame[23:0] + flash_addr_t'(out_cnt[4:3]);
    assign out_byte = byte_at(out_addr);

    // Command and address bits are taken on the rising edge.
    always @(posedge spi_sck or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            in_cnt <= 6'd0;
        end else if (in_cnt != 6'd32) begin
            frame  <= {frame[30:0], spi_mosi};
            in_cnt <= in_cnt + 6'd1;
        end
    end

    // Data leaves on the falling edge once the whole frame is in.
    always @(negedge spi_sck or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            out_cnt  <= 5'd0;
            spi_miso <= 1'b0;
        end else if (in_cnt == 6'd32) begin
            if (frame[31:24] == read_opcode) begin
                spi_miso <= out_byte[3'd7 - out_cnt[2:0]];
            end else begin
                // Unknown commands read as zero.
                spi_miso <= 1'b0;
            end
            out_cnt <= out_cnt + 5'd1;
        end
    end

endmodule

// File: flash_emu_top.sv
`timescale 1ns/1ps

module flash_emu_top import flash_emu_pkg::*; #(
    parameter flash_addr_t PORT0_BASE = 24'h7E0000,
    parameter flash_addr_t PORT1_BASE = 24'h100000,
    parameter int          SCK_DIV_LOG2 = 1
) (
    input  logic        SIM_CLK,
    input  logic        reset,
    input  logic        ce0_n,
    input  logic        oe0_n,
    input  word_addr_t  addr0,
    output flash_word_t dq0,
    output logic        dq0_oe,
    output logic        ready0,
    input  logic        ce1_n,
    input  logic        oe1_n,
    input  word_addr_t  addr1,
    output flash_word_t dq1,
    output logic        dq1_oe,
    output logic        ready1,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso
);

    logic        req0;
    logic        req1;
    flash_addr_t req_addr0;
    flash_addr_t req_addr1;
    logic        done0;
    logic        done1;
    flash_word_t word0;
    flash_word_t word1;
    logic        start;
    flash_addr_t rd_addr;
    logic        rd_done;
    flash_word_t rd_word;

    rom_port #(
        .BASE(PORT0_BASE)
    ) port0_i (
        .SIM_CLK  (SIM_CLK),
        .reset    (reset),
        .ce_n     (ce0_n),
        .oe_n     (oe0_n),
        .addr     (addr0),
        .dq       (dq0),
        .dq_oe    (dq0_oe),
        .ready    (ready0),
        .req      (req0),
        .req_addr (req_addr0),
        .done     (done0),
        .word     (word0)
    );

    rom_port #(
        .BASE(PORT1_BASE)
    ) port1_i (
        .SIM_CLK  (SIM_CLK),
        .reset    (reset),
        .ce_n     (ce1_n),
        .oe_n     (oe1_n),
        .addr     (addr1),
        .dq       (dq1),
        .dq_oe    (dq1_oe),
        .ready    (ready1),
        .req      (req1),
        .req_addr (req_addr1),
        .done     (done1),
        .word     (word1)
    );

    flash_arbiter flash_arbiter_i (
        .SIM_CLK   (SIM_CLK),
        .reset     (reset),
        .req0      (req0),
        .req1      (req1),
        .req_addr0 (req_addr0),
        .req_addr1 (req_addr1),
        .done0     (done0),
        .done1     (done1),
        .word0     (word0),
        .word1     (word1),
        .start     (start),
        .addr      (rd_addr),
        .rd_done   (rd_done),
        .rd_word   (rd_word)
    );

    spi_flash_reader #(
        .SCK_DIV_LOG2(SCK_DIV_LOG2)
    ) spi_flash_reader_i (
        .SIM_CLK  (SIM_CLK),
        .reset    (reset),
        .start    (start),
        .addr     (rd_addr),
        .done     (rd_done),
        .word     (rd_word),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

// File: spi_flash_reader.sv
`timescale 1ns/1ps

module spi_flash_reader import flash_emu_pkg::*; #(
    parameter int SCK_DIV_LOG2 = 1
) (
    input  logic        SIM_CLK,
    input  logic        reset,
    input  logic        start,
    input  flash_addr_t addr,
    output logic        done,
    output flash_word_t word,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso
);

    // One SPI clock period spans 2**(SCK_DIV_LOG2 + 1) system clocks.
    localparam int CNT_W = SCK_DIV_LOG2 + 1;
    localparam logic [CNT_W-1:0] RISE_AT = CNT_W'((2 ** SCK_DIV_LOG2) - 1);
    localparam logic [CNT_W-1:0] FALL_AT = CNT_W'((2 ** CNT_W) - 1);
    localparam logic [4:0] CMD_LAST = 5'd31;
    localparam logic [4:0] DATA_LAST = 5'd15;

    reader_state_t    state;
    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] div_next;
    logic [4:0]       bit_cnt;
    logic [31:0]      tx_shift;
    flash_word_t      rx_shift;
    logic             sck_rise;
    logic             sck_fall;

    // The top bit of the divider is the SPI clock itself.
    assign div_next = div_cnt + 1'b1;
    assign sck_rise = (div_cnt == RISE_AT);
    assign sck_fall = (div_cnt == FALL_AT);

    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            state    <= rd_idle;
            spi_cs_n <= 1'b1;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b0;
            done     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                rd_idle: begin
                    if (start) begin
                        spi_cs_n <= 1'b0;
                        // Mode 0 needs the first bit in place before the first rising edge.
                        spi_mosi <= read_opcode[7];
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        state    <= rd_command;
                    end
                end
                rd_command: begin
                    div_cnt <= div_next;
                    spi_sck <= div_next[CNT_W-1];
                    if (sck_fall) begin
                        if (bit_cnt == CMD_LAST) begin
                            bit_cnt  <= '0;
                            spi_mosi <= 1'b0;
                            state    <= rd_data;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            spi_mosi <= tx_shift[30];
                        end
                    end
                end
                rd_data: begin
                    div_cnt <= div_next;
                    spi_sck <= div_next[CNT_W-1];
                    if (sck_fall) begin
                        if (bit_cnt == DATA_LAST) begin
                            // Chip-select goes high with the last falling edge.
                            spi_cs_n <= 1'b1;
                            state    <= rd_finish;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                rd_finish: begin
                    done  <= 1'b1;
                    state <= rd_idle;
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // The flash shifts data out on the falling edge, so it is stable at the rise.
    always_ff @(posedge SIM_CLK) begin
        if (state == rd_idle && start) begin
            tx_shift <= {read_opcode, addr};
        end else if (state == rd_command && sck_fall) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
        if (state == rd_data && sck_rise) begin
            rx_shift <= {rx_shift[14:0], spi_miso};
        end
        if (state == rd_finish) begin
            word <= rx_shift;
        end
    end

endmodule

// File: flash_arbiter.sv
`timescale 1ns/1ps

module flash_arbiter import flash_emu_pkg::*; (
    input  logic        SIM_CLK,
    input  logic        reset,
    input  logic        req0,
    input  logic        req1,
    input  flash_addr_t req_addr0,
    input  flash_addr_t req_addr1,
    output logic        done0,
    output logic        done1,
    output flash_word_t word0,
    output flash_word_t word1,
    output logic        start,
    output flash_addr_t addr,
    input  logic        rd_done,
    input  flash_word_t rd_word
);

    logic        pend0;
    logic        pend1;
    flash_addr_t addr0_q;
    flash_addr_t addr1_q;
    logic        busy;
    logic        owner;
    logic        want0;
    logic        want1;
    logic        free;
    logic        issue;
    logic        pick;
    flash_addr_t pick_addr;

    // A request arriving this cycle counts at once, saving a cycle.
    assign want0 = pend0 | req0;
    assign want1 = pend1 | req1;

    // The reader is idle again in the cycle that carries its done pulse.
    assign free  = ~busy | rd_done;
    assign issue = free & (want0 | want1);

    // Owner also remembers the port served last, which loses a tie.
    assign pick = (want0 & want1) ? ~owner : want1;

    always_comb begin
        if (pick) begin
            pick_addr = pend1 ? addr1_q : req_addr1;
        end else begin
            pick_addr = pend0 ? addr0_q : req_addr0;
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            pend0 <= 1'b0;
            pend1 <= 1'b0;
            busy  <= 1'b0;
            owner <= 1'b1;
            start <= 1'b0;
            done0 <= 1'b0;
            done1 <= 1'b0;
        end else begin
            start <= issue;
            done0 <= rd_done & ~owner;
            done1 <= rd_done & owner;
            pend0 <= want0 & ~(issue & ~pick);
            pend1 <= want1 & ~(issue & pick);
            if (issue) begin
                busy  <= 1'b1;
                owner <= pick;
            end else if (rd_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (req0) begin
            addr0_q <= req_addr0;
        end
        if (req1) begin
            addr1_q <= req_addr1;
        end
        if (issue) begin
            addr <= pick_addr;
        end
        if (rd_done && !owner) begin
            word0 <= rd_word;
        end
        if (rd_done && owner) begin
            word1 <= rd_word;
        end
    end

endmodule

// File: rom_port.sv
`timescale 1ns/1ps

module rom_port import flash_emu_pkg::*; #(
    parameter flash_addr_t BASE = 24'h000000
) (
    input  logic        SIM_CLK,
    input  logic        reset,
    input  logic        ce_n,
    input  logic        oe_n,
    input  word_addr_t  addr,
    output flash_word_t dq,
    output logic        dq_oe,
    output logic        ready,
    output logic        req,
    output flash_addr_t req_addr,
    input  logic        done,
    input  flash_word_t word
);

    typedef enum logic [1:0] {
        port_idle,
        port_wait,
        port_hold
    } port_state_t;

    port_state_t state;
    flash_word_t word_q;
    logic        oe_q;
    logic        select;
    logic        capture;

    // A select seen while idle starts exactly one flash read.
    assign select  = (state == port_idle) && !ce_n;
    assign capture = (state == port_wait) && done;

    assign dq    = word_q;
    assign dq_oe = ready & oe_q;

    always_ff @(posedge SIM_CLK) begin
        if (reset) begin
            state <= port_idle;
            ready <= 1'b0;
            req   <= 1'b0;
            oe_q  <= 1'b0;
        end else begin
            oe_q <= ~oe_n;
            req  <= select;
            case (state)
                port_idle: begin
                    if (!ce_n) begin
                        state <= port_wait;
                    end
                end
                port_wait: begin
                    if (done) begin
                        ready <= 1'b1;
                        state <= port_hold;
                    end
                end
                port_hold: begin
                    // The word stays on the bus until chip-enable is released.
                    if (ce_n) begin
                        ready <= 1'b0;
                        state <= port_idle;
                    end
                end
                default: begin
                    state <= port_idle;
                end
            endcase
        end
    end

    // Each word is two bytes in the serial flash, so the word address is doubled.
    always_ff @(posedge SIM_CLK) begin
        if (select) begin
            req_addr <= BASE + flash_addr_t'({addr, 1'b0});
        end
        if (capture) begin
            word_q <= word;
        end
    end

endmodule

// File: flash_emu_pkg.sv
package flash_emu_pkg;

    // Word address on a parallel port, 128K words of 16 bits.
    typedef logic [16:0] word_addr_t;

    // Byte address in the serial flash.
    typedef logic [23:0] flash_addr_t;

    // One data word as presented on a parallel port.
    typedef logic [15:0] flash_word_t;

    // Serial flash read command, followed by a 24-bit address.
    localparam logic [7:0] read_opcode = 8'h03;

    // The reader sends the command frame, then clocks in data and
    // raises chip-select in finish before reporting the word.
    typedef enum logic [1:0] {
        rd_idle,
        rd_command,
        rd_data,
        rd_finish
    } reader_state_t;

endpackage
